//--- filelist.f
rtl/pfd_pkg.sv
rtl/edge_sync.sv
rtl/edge_divider.sv
rtl/phase_freq_detector.sv
rtl/lock_detector.sv
rtl/ref_monitor.sv
rtl/pll_top.sv
verif/pll_top_tb.sv

//--- Makefile
# Verilator build and run for the pll front end

VERILATOR ?= verilator
TOP       ?= pll_top_tb
FILELIST  ?= filelist.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal

SRCS := $(shell grep -v '^+' $(FILELIST))
BIN  := $(BUILD_DIR)/V$(TOP)

.PHONY: all build run check clean

all: run

build: $(BIN)

# rebuilt only when a source or the file list changes
$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(BIN)
	-./$(BIN) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -q "=== PASS ===" $(LOG)

check:
	@test -f $(LOG) || (echo "no log, run the simulation first"; exit 1)
	@grep -q "=== PASS ===" $(LOG) && echo "simulation passed" || \
		(echo "simulation failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- verif/pll_top_tb.sv
/*
 * pll_top_tb
 * drives square waves on both pll inputs and checks the front end
 * with concurrent assertions, one report line per test
 */

`timescale 1ns/1ps

module pll_top_tb;

	localparam int CLK_NS      = 4;
	localparam int REF_DIV     = 5;
	localparam int OSC_DIV     = 6;
	localparam int LOCK_WINDOW = 4;
	localparam int LOCK_COUNT  = 3;
	localparam int REF_TIMEOUT = 40;

	// 5 * 12 = 6 * 10, both divided waves share a 120 cycle period
	localparam int REF_HALF   = 6;
	localparam int OSC_HALF   = 5;
	localparam int DIV_PERIOD = 2 * REF_DIV * 2 * REF_HALF;

	// osc_div rises 2 cycles after ref_div when both waves start together
	localparam int WIDE_OFFSET = 10;
	localparam int ALONE_EDGES = 4 * OSC_DIV;

	// 22 divided periods over all tests, plus reset, osc alone and gaps
	localparam int TOTAL_CYCLES = 24 + 22 * DIV_PERIOD + ALONE_EDGES * 2 * OSC_HALF + 128;
	localparam int WATCHDOG_NS  = TOTAL_CYCLES * CLK_NS * 3 / 2;

	localparam int MODE_NONE = 0;
	localparam int MODE_LEAD = 1;
	localparam int MODE_LAG  = 2;
	localparam int MODE_LOSS = 3;
	localparam int MODE_ACQ  = 4;

	logic ref_in;
	logic osc_8k;
	logic ref_sig;
	logic osc_sig;
	logic vcxo_out;
	logic pump_up;
	logic pump_dn;
	logic ref_div;
	logic osc_div;
	logic lock_n;
	logic ref_missing;

	// monitor state, sampled on the same edges as the DUT
	logic ref_q;
	logic osc_q;
	logic ref_div_q;
	logic osc_div_q;
	int ref_rises;
	int osc_rises;
	int ref_mark;
	int osc_mark;
	int since_ref;
	int periods;
	int up_cycles;
	int dn_cycles;
	int miss_cycles;

	// test bookkeeping
	string cur_test = "none";
	int mode = MODE_NONE;
	logic idle_check = 1'b0;
	int errors = 0;
	int err_base = 0;
	int period_base = 0;
	int tests_passed = 0;
	int tests_failed = 0;
	integer seed = 45;

	pll_top
	#(
		.REF_DIV     (16'(REF_DIV)),
		.OSC_DIV     (16'(OSC_DIV)),
		.LOCK_WINDOW (12'(LOCK_WINDOW)),
		.LOCK_COUNT  (12'(LOCK_COUNT)),
		.REF_TIMEOUT (16'(REF_TIMEOUT))
	) DUT
	(
		.ref_in      (ref_in),
		.osc_8k      (osc_8k),
		.ref_sig     (ref_sig),
		.osc_sig     (osc_sig),
		.vcxo_out    (vcxo_out),
		.pump_up     (pump_up),
		.pump_dn     (pump_dn),
		.ref_div     (ref_div),
		.osc_div     (osc_div),
		.lock_n      (lock_n),
		.ref_missing (ref_missing)
	);

	initial
	begin
		ref_in = 1'b0;
		forever #(CLK_NS / 2) ref_in = ~ref_in;
	end

	// edges counted here are the ones the wave tasks drove
	always @(posedge ref_in or posedge osc_8k)
	begin
		if (osc_8k)
		begin
			ref_q       <= 1'b0;
			osc_q       <= 1'b0;
			ref_div_q   <= 1'b0;
			osc_div_q   <= 1'b0;
			ref_rises   <= 0;
			osc_rises   <= 0;
			ref_mark    <= 0;
			osc_mark    <= 0;
			since_ref   <= 0;
			periods     <= 0;
			up_cycles   <= 0;
			dn_cycles   <= 0;
			miss_cycles <= 0;
		end
		else
		begin
			ref_q     <= ref_sig;
			osc_q     <= osc_sig;
			ref_div_q <= ref_div;
			osc_div_q <= osc_div;
			if (ref_sig && !ref_q)
			begin
				ref_rises <= ref_rises + 1;
				since_ref <= 0;
			end
			else if (since_ref < 10000)
			begin
				since_ref <= since_ref + 1;
			end
			if (osc_sig && !osc_q)
				osc_rises <= osc_rises + 1;
			// a toggle closes one half period of the divider
			if (ref_div != ref_div_q)
				ref_mark <= ref_rises;
			if (osc_div != osc_div_q)
				osc_mark <= osc_rises;
			// same edge on which the lock detector closes a period
			if (ref_div && !ref_div_q)
				periods <= periods + 1;
			if (pump_up)
				up_cycles <= up_cycles + 1;
			if (pump_dn)
				dn_cycles <= dn_cycles + 1;
			if (ref_missing)
				miss_cycles <= miss_cycles + 1;
		end
	end

	// everything quiet through reset and before the first strobe
	a_idle: assert property (@(posedge ref_in) idle_check |->
		(!pump_up && !pump_dn && !ref_div && !osc_div && !vcxo_out && !ref_missing && lock_n))
		else
		begin
			$display("%s: an output left its reset value before any input edge", cur_test);
			errors++;
		end

	a_ref_ratio: assert property (@(posedge ref_in) disable iff (osc_8k)
		$changed(ref_div) |-> (ref_rises - ref_mark) == REF_DIV)
		else
		begin
			$display("MISMATCH %s ref_div half period edges expected %0d actual %0d",
				cur_test, REF_DIV, $sampled(ref_rises) - $sampled(ref_mark));
			errors++;
		end

	a_osc_ratio: assert property (@(posedge ref_in) disable iff (osc_8k)
		$changed(osc_div) |-> (osc_rises - osc_mark) == OSC_DIV)
		else
		begin
			$display("MISMATCH %s osc_div half period edges expected %0d actual %0d",
				cur_test, OSC_DIV, $sampled(osc_rises) - $sampled(osc_mark));
			errors++;
		end

	a_pump_excl: assert property (@(posedge ref_in) disable iff (osc_8k)
		!(pump_up && pump_dn))
		else
		begin
			$display("%s: pump_up and pump_dn high in the same cycle", cur_test);
			errors++;
		end

	a_lead_up_only: assert property (@(posedge ref_in) disable iff (osc_8k)
		(mode == MODE_LEAD) |-> !pump_dn)
		else
		begin
			$display("MISMATCH %s pump_dn expected 0 actual 1", cur_test);
			errors++;
		end

	a_lag_dn_only: assert property (@(posedge ref_in) disable iff (osc_8k)
		(mode == MODE_LAG) |-> !pump_up)
		else
		begin
			$display("MISMATCH %s pump_up expected 0 actual 1", cur_test);
			errors++;
		end

	// first period of the test still belongs to the previous one
	a_lock_lost: assert property (@(posedge ref_in) disable iff (osc_8k)
		(mode == MODE_LOSS && (periods - period_base) >= 2) |-> lock_n)
		else
		begin
			$display("MISMATCH %s lock_n expected 1 actual 0", cur_test);
			errors++;
		end

	a_lock_wait: assert property (@(posedge ref_in) disable iff (osc_8k)
		(mode == MODE_ACQ && (periods - period_base) <= LOCK_COUNT) |-> lock_n)
		else
		begin
			$display("MISMATCH %s lock_n expected 1 actual 0", cur_test);
			errors++;
		end

	a_lock_held: assert property (@(posedge ref_in) disable iff (osc_8k)
		(mode == MODE_ACQ && (periods - period_base) > LOCK_COUNT) |-> !lock_n)
		else
		begin
			$display("MISMATCH %s lock_n expected 0 actual 1", cur_test);
			errors++;
		end

	// sync and edge detect add 3 cycles to the watchdog count
	a_miss_rise: assert property (@(posedge ref_in) disable iff (osc_8k)
		(since_ref >= REF_TIMEOUT + 3) |-> ref_missing)
		else
		begin
			$display("MISMATCH %s ref_missing expected 1 actual 0", cur_test);
			errors++;
		end

	a_miss_clear: assert property (@(posedge ref_in) disable iff (osc_8k)
		(since_ref >= 4 && since_ref < REF_TIMEOUT) |-> !ref_missing)
		else
		begin
			$display("MISMATCH %s ref_missing expected 0 actual 1", cur_test);
			errors++;
		end

	a_holdover: assert property (@(posedge ref_in) disable iff (osc_8k)
		ref_missing |-> (vcxo_out == osc_div))
		else
		begin
			$display("MISMATCH %s vcxo_out expected %b actual %b",
				cur_test, $sampled(osc_div), $sampled(vcxo_out));
			errors++;
		end

	// with the reference present the output follows the last pump direction
	a_vcxo_up: assert property (@(posedge ref_in) disable iff (osc_8k)
		pump_up |=> (ref_missing || vcxo_out))
		else
		begin
			$display("MISMATCH %s vcxo_out after pump_up expected 1 actual 0", cur_test);
			errors++;
		end

	a_vcxo_dn: assert property (@(posedge ref_in) disable iff (osc_8k)
		pump_dn |=> (ref_missing || !vcxo_out))
		else
		begin
			$display("MISMATCH %s vcxo_out after pump_dn expected 0 actual 1", cur_test);
			errors++;
		end

	// no pulse means the driven level is kept
	a_vcxo_hold: assert property (@(posedge ref_in) disable iff (osc_8k)
		(!pump_up && !pump_dn && !ref_missing) |=> (ref_missing || $stable(vcxo_out)))
		else
		begin
			$display("%s: vcxo_out changed with no pump pulse", cur_test);
			errors++;
		end

	function automatic int small_offset(input int span);
		int r;
		r = $random(seed);
		return (r & 32'h7fff_ffff) % span;
	endfunction

	task automatic set_level(input bit on_osc, input logic level);
		if (on_osc)
			osc_sig = level;
		else
			ref_sig = level;
	endtask

	// call on a rising clock edge, each level lands 1 ns after an edge
	task automatic drive_wave(input bit on_osc, input int half, input int edges,
		input int delay);
		repeat (delay) @(posedge ref_in);
		repeat (edges)
		begin
			#1;
			set_level(on_osc, 1'b1);
			repeat (half) @(posedge ref_in);
			#1;
			set_level(on_osc, 1'b0);
			repeat (half) @(posedge ref_in);
		end
	endtask

	// whole divided periods, so both dividers end at count zero and low
	task automatic run_pair(input int n, input int ref_delay, input int osc_delay);
		fork
			drive_wave(1'b0, REF_HALF, n * 2 * REF_DIV, ref_delay);
			drive_wave(1'b1, OSC_HALF, n * 2 * OSC_DIV, osc_delay);
		join
	endtask

	task automatic open_test(input string name, input int m);
		@(posedge ref_in);
		cur_test    = name;
		mode        = m;
		err_base    = errors;
		period_base = periods;
	endtask

	task automatic note_error(input string what);
		$display("%s: %s", cur_test, what);
		errors++;
	endtask

	task automatic close_test();
		mode = MODE_NONE;
		if (errors == err_base)
		begin
			tests_passed++;
			$display("test %s passed", cur_test);
		end
		else
		begin
			tests_failed++;
			$display("test %s failed with %0d errors", cur_test, errors - err_base);
		end
	endtask

	task automatic check_reset();
		cur_test = "reset_state";
		err_base = errors;
		// outputs are reset by the first edge, checking starts after it
		@(posedge ref_in);
		idle_check = 1'b1;
		repeat (15) @(posedge ref_in);
		#1 osc_8k = 1'b0;
		repeat (8) @(posedge ref_in);
		idle_check = 1'b0;
		close_test();
	endtask

	task automatic check_phase(input string name, input int m, input int ref_delay,
		input int osc_delay);
		int up_base;
		int dn_base;
		open_test(name, m);
		up_base = up_cycles;
		dn_base = dn_cycles;
		run_pair(4, ref_delay, osc_delay);
		if (m == MODE_LEAD && up_cycles == up_base)
			note_error("no pump_up pulse with the reference leading");
		if (m == MODE_LAG && dn_cycles == dn_base)
			note_error("no pump_dn pulse with the reference lagging");
		close_test();
	endtask

	task automatic check_ref_loss();
		int miss_base;
		open_test("ref_loss", MODE_NONE);
		miss_base = miss_cycles;
		// vcxo keeps running with the reference stopped
		drive_wave(1'b1, OSC_HALF, ALONE_EDGES, 0);
		if (miss_cycles == miss_base)
			note_error("ref_missing never rose after ref_sig stopped");
		run_pair(2, 0, 0);
		close_test();
	endtask

	initial
	begin
		osc_8k  = 1'b1;
		ref_sig = 1'b0;
		osc_sig = 1'b0;
		check_reset();

		open_test("divider_ratio", MODE_NONE);
		run_pair(2, 0, small_offset(2));
		close_test();

		// lead in cycles is osc_delay - ref_delay + 2
		check_phase("phase_lead", MODE_LEAD, 0, small_offset(2));
		check_phase("phase_lag", MODE_LAG, 4 + small_offset(2), 0);

		open_test("lock_loss", MODE_LOSS);
		run_pair(4, 0, WIDE_OFFSET);
		close_test();

		open_test("lock_acquire", MODE_ACQ);
		run_pair(6, 0, small_offset(2));
		if (lock_n)
			note_error("lock_n still high after the lock periods");
		close_test();

		check_ref_loss();

		$display("tests passed %0d failed %0d, assertion errors %0d",
			tests_passed, tests_failed, errors);
		if (tests_failed == 0 && errors == 0)
			$display("=== PASS ===");
		else
			$display("=== FAIL ===");
		$finish;
	end

	initial
	begin
		#(WATCHDOG_NS);
		$display("timeout: run exceeded %0d ns in test %s", WATCHDOG_NS, cur_test);
		$display("=== FAIL ===");
		$finish;
	end

endmodule

//--- rtl/pll_top.sv
/*
 * pll_top
 * digital pll front end, divides reference and vcxo to the comparison
 * rate, runs the pfd and lock detector, and selects the loop output
 */

`timescale 1ns/1ps

module pll_top
#(
	parameter logic [pfd_pkg::DIV_W-1:0]  REF_DIV     = pfd_pkg::REF_DIV_DEF,
	parameter logic [pfd_pkg::DIV_W-1:0]  OSC_DIV     = pfd_pkg::OSC_DIV_DEF,
	parameter logic [pfd_pkg::LOCK_W-1:0] LOCK_WINDOW = 12'd8,
	parameter logic [pfd_pkg::LOCK_W-1:0] LOCK_COUNT  = 12'd16,
	parameter logic [pfd_pkg::TMO_W-1:0]  REF_TIMEOUT = 16'd1000
)
(
	input  logic ref_in,
	input  logic osc_8k,
	input  logic ref_sig,
	input  logic osc_sig,
	output logic vcxo_out,
	output logic pump_up,
	output logic pump_dn,
	output logic ref_div,
	output logic osc_div,
	output logic lock_n,
	output logic ref_missing
);

	logic                ref_stb;
	logic                osc_stb;
	logic                pump_hold;
	pfd_pkg::pfd_state_t pfd_state;

	// input conditioning, levels are not needed past the edge detect
	edge_sync u_ref_sync
	(
		.ref_in   (ref_in),
		.osc_8k   (osc_8k),
		.async_in (ref_sig),
		.level    (),
		.edge_stb (ref_stb)
	);

	edge_sync u_osc_sync
	(
		.ref_in   (ref_in),
		.osc_8k   (osc_8k),
		.async_in (osc_sig),
		.level    (),
		.edge_stb (osc_stb)
	);

	// both paths down to the comparison rate
	edge_divider #(.HALF_COUNT(REF_DIV)) u_ref_div
	(
		.ref_in   (ref_in),
		.osc_8k   (osc_8k),
		.edge_stb (ref_stb),
		.div_out  (ref_div)
	);

	edge_divider #(.HALF_COUNT(OSC_DIV)) u_osc_div
	(
		.ref_in   (ref_in),
		.osc_8k   (osc_8k),
		.edge_stb (osc_stb),
		.div_out  (osc_div)
	);

	phase_freq_detector u_pfd
	(
		.ref_in  (ref_in),
		.osc_8k  (osc_8k),
		.ref_div (ref_div),
		.osc_div (osc_div),
		.pump_up (pump_up),
		.pump_dn (pump_dn),
		.state   (pfd_state)
	);

	lock_detector #(.LOCK_WINDOW(LOCK_WINDOW), .LOCK_COUNT(LOCK_COUNT)) u_lock
	(
		.ref_in  (ref_in),
		.osc_8k  (osc_8k),
		.ref_div (ref_div),
		.state   (pfd_state),
		.lock_n  (lock_n)
	);

	ref_monitor #(.REF_TIMEOUT(REF_TIMEOUT)) u_ref_mon
	(
		.ref_in      (ref_in),
		.osc_8k      (osc_8k),
		.ref_stb     (ref_stb),
		.ref_missing (ref_missing)
	);

	// tri-state pump emulation: drive high on up, low on down, else keep
	always_ff @(posedge ref_in or posedge osc_8k)
	begin
		if (osc_8k)
			pump_hold <= 1'b0;
		else if (pump_up)
			pump_hold <= 1'b1;
		else if (pump_dn)
			pump_hold <= 1'b0;
	end

	// with no reference the divided vcxo square wave parks the filter at mid-rail
	assign vcxo_out = ref_missing ? osc_div : pump_hold;

endmodule

//--- rtl/ref_monitor.sv
/*
 * ref_monitor
 * watchdog on reference edges, flags a missing reference after
 * REF_TIMEOUT quiet cycles and clears on the next edge
 */

`timescale 1ns/1ps

module ref_monitor
#(
	parameter logic [pfd_pkg::TMO_W-1:0] REF_TIMEOUT = 16'd1000
)
(
	input  logic ref_in,
	input  logic osc_8k,
	input  logic ref_stb,
	output logic ref_missing
);

	localparam logic [pfd_pkg::TMO_W-1:0] TMO_LAST = REF_TIMEOUT - 1'b1;

	// cycles since the last reference strobe, stops at TMO_LAST
	logic [pfd_pkg::TMO_W-1:0] quiet_cnt;

	always_ff @(posedge ref_in or posedge osc_8k)
	begin
		if (osc_8k)
		begin
			quiet_cnt   <= '0;
			ref_missing <= 1'b0;
		end
		else if (ref_stb)
		begin
			// any edge proves the reference is back
			quiet_cnt   <= '0;
			ref_missing <= 1'b0;
		end
		else if (quiet_cnt == TMO_LAST)
		begin
			// counter parks here until the next strobe
			ref_missing <= 1'b1;
		end
		else
		begin
			quiet_cnt <= quiet_cnt + 1'b1;
		end
	end

	// recovery is immediate, no hysteresis
	a_clear_on_stb: assert property (@(posedge ref_in) disable iff (osc_8k)
		ref_stb |=> !ref_missing)
		else $error("ref_monitor: ref_missing still high after a strobe");

endmodule

//--- rtl/lock_detector.sv
/*
 * lock_detector
 * measures the longest pump pulse in each ref_div period and
 * drives lock_n low after LOCK_COUNT consecutive narrow periods
 */

`timescale 1ns/1ps

module lock_detector
#(
	parameter logic [pfd_pkg::LOCK_W-1:0] LOCK_WINDOW = 12'd8,
	parameter logic [pfd_pkg::LOCK_W-1:0] LOCK_COUNT  = 12'd16
)
(
	input  logic                ref_in,
	input  logic                osc_8k,
	input  logic                ref_div,
	input  pfd_pkg::pfd_state_t state,
	output logic                lock_n
);

	localparam logic [pfd_pkg::LOCK_W-1:0] RUN_MAX    = '1;
	localparam logic [pfd_pkg::LOCK_W-1:0] COUNT_LAST = LOCK_COUNT - 1'b1;

	logic                      ref_d;
	logic                      ref_rise;
	logic [pfd_pkg::LOCK_W-1:0] run_cnt;
	logic [pfd_pkg::LOCK_W-1:0] run_next;
	logic [pfd_pkg::LOCK_W-1:0] peak;
	logic [pfd_pkg::LOCK_W-1:0] peak_next;
	logic [pfd_pkg::LOCK_W-1:0] good_cnt;
	logic                      period_good;

	assign ref_rise = ref_div & ~ref_d;

	always_comb
	begin
		// length of the current non-idle run, saturating
		if (state != pfd_pkg::PFD_IDLE)
			run_next = (run_cnt == RUN_MAX) ? run_cnt : run_cnt + 1'b1;
		else
			run_next = '0;
		// widest pulse so far in this period, current run included
		peak_next   = (run_next > peak) ? run_next : peak;
		period_good = (peak_next <= LOCK_WINDOW);
	end

	always_ff @(posedge ref_in or posedge osc_8k)
	begin
		if (osc_8k)
		begin
			ref_d    <= 1'b0;
			run_cnt  <= '0;
			peak     <= '0;
			good_cnt <= '0;
			lock_n   <= 1'b1;
		end
		else
		begin
			ref_d   <= ref_div;
			run_cnt <= run_next;
			if (ref_rise)
			begin
				// close the period and start a fresh peak
				peak <= '0;
				if (!period_good)
				begin
					// one wide pulse drops lock at once
					good_cnt <= '0;
					lock_n   <= 1'b1;
				end
				else
				begin
					if (good_cnt != LOCK_COUNT)
						good_cnt <= good_cnt + 1'b1;
					if (good_cnt >= COUNT_LAST)
						lock_n <= 1'b0;
				end
			end
			else
			begin
				peak <= peak_next;
			end
		end
	end

endmodule

//--- rtl/phase_freq_detector.sv
/*
 * phase_freq_detector
 * classic three state pfd on the two divided signals,
 * pump_up when the reference leads, pump_dn when the vcxo leads
 */

`timescale 1ns/1ps

module phase_freq_detector
(
	input  logic                ref_in,
	input  logic                osc_8k,
	input  logic                ref_div,
	input  logic                osc_div,
	output logic                pump_up,
	output logic                pump_dn,
	output pfd_pkg::pfd_state_t state
);

	logic ref_d;
	logic osc_d;
	logic ref_rise;
	logic osc_rise;
	pfd_pkg::pfd_state_t state_next;

	// both inputs already sit in the ref_in domain, one flop is enough
	assign ref_rise = ref_div & ~ref_d;
	assign osc_rise = osc_div & ~osc_d;

	always_comb
	begin
		state_next = state;
		case (state)
			pfd_pkg::PFD_IDLE:
			begin
				// coincident edges cancel, no pulse at all
				if (ref_rise && !osc_rise)
					state_next = pfd_pkg::PFD_UP;
				else if (osc_rise && !ref_rise)
					state_next = pfd_pkg::PFD_DN;
			end
			pfd_pkg::PFD_UP:
			begin
				// vcxo edge arrives, both flops would be set, clear them
				if (osc_rise)
					state_next = pfd_pkg::PFD_IDLE;
			end
			pfd_pkg::PFD_DN:
			begin
				if (ref_rise)
					state_next = pfd_pkg::PFD_IDLE;
			end
			default:
				state_next = pfd_pkg::PFD_IDLE;
		endcase
	end

	always_ff @(posedge ref_in or posedge osc_8k)
	begin
		if (osc_8k)
		begin
			ref_d <= 1'b0;
			osc_d <= 1'b0;
			state <= pfd_pkg::PFD_IDLE;
		end
		else
		begin
			ref_d <= ref_div;
			osc_d <= osc_div;
			state <= state_next;
		end
	end

	// pumps decode straight from the state register
	assign pump_up = (state == pfd_pkg::PFD_UP);
	assign pump_dn = (state == pfd_pkg::PFD_DN);

	// the loop filter must never see both pumps at once
	a_pump_excl: assert property (@(posedge ref_in) disable iff (osc_8k)
		!(pump_up && pump_dn))
		else $error("phase_freq_detector: pump_up and pump_dn both high");

endmodule

//--- rtl/edge_divider.sv
/*
 * edge_divider
 * counts edge strobes and toggles a square wave every HALF_COUNT strobes,
 * giving one output period per 2*HALF_COUNT input edges
 */

`timescale 1ns/1ps

module edge_divider
#(
	parameter logic [pfd_pkg::DIV_W-1:0] HALF_COUNT = pfd_pkg::REF_DIV_DEF
)
(
	input  logic ref_in,
	input  logic osc_8k,
	input  logic edge_stb,
	output logic div_out
);

	// terminal count, the strobe that sees this value toggles the output
	localparam logic [pfd_pkg::DIV_W-1:0] LAST = HALF_COUNT - 1'b1;

	logic [pfd_pkg::DIV_W-1:0] count;

	always_ff @(posedge ref_in or posedge osc_8k)
	begin
		if (osc_8k)
		begin
			count   <= '0;
			div_out <= 1'b0;
		end
		else if (edge_stb)
		begin
			if (count == LAST)
			begin
				// Nth strobe, restart and flip the half period
				count   <= '0;
				div_out <= ~div_out;
			end
			else
			begin
				count <= count + 1'b1;
			end
		end
	end

	// count wraps at LAST, never beyond
	a_count_range: assert property (@(posedge ref_in) disable iff (osc_8k)
		count <= LAST)
		else $error("edge_divider: count %0d above %0d", count, LAST);

endmodule

//--- rtl/edge_sync.sv
/*
 * edge_sync
 * two flop synchronizer for an asynchronous square wave,
 * with a registered level and a one cycle rising edge strobe
 */

`timescale 1ns/1ps

module edge_sync
(
	input  logic ref_in,
	input  logic osc_8k,
	input  logic async_in,
	output logic level,
	output logic edge_stb
);

	// metastability chain, sync_q[0] is the first stage
	logic [1:0] sync_q;

	always_ff @(posedge ref_in or posedge osc_8k)
	begin
		if (osc_8k)
		begin
			sync_q   <= 2'b00;
			level    <= 1'b0;
			edge_stb <= 1'b0;
		end
		else
		begin
			sync_q   <= {sync_q[0], async_in};
			// third stage holds the previous synchronized level
			level    <= sync_q[1];
			// high only when the new sample is 1 and the old one 0
			edge_stb <= sync_q[1] & ~level;
		end
	end

	// a strobe is a single cycle, the level has to drop before the next one
	a_stb_single: assert property (@(posedge ref_in) disable iff (osc_8k)
		edge_stb |=> !edge_stb)
		else $error("edge_sync: edge_stb held for two cycles");

endmodule

//--- rtl/pfd_pkg.sv
/*
 * pfd_pkg
 * widths, default divider ratios and the detector state encoding
 * shared by the pll front end blocks
 */

package pfd_pkg;

	// divider counter width, enough for 10 MHz / 8 kHz half periods
	parameter int DIV_W = 16;

	// reference watchdog counter width
	parameter int TMO_W = 16;

	// pulse width and good period counters
	parameter int LOCK_W = 12;

	// 10 MHz / (2 * 625) = 8 kHz
	parameter logic [DIV_W-1:0] REF_DIV_DEF = 16'd625;

	// 12.288 MHz / (2 * 768) = 8 kHz
	parameter logic [DIV_W-1:0] OSC_DIV_DEF = 16'd768;

	// three state pfd
	// up and dn are one-hot so the pumps decode from a single bit each
	typedef enum logic [1:0]
	{
		PFD_IDLE = 2'b00,
		PFD_UP   = 2'b01,
		PFD_DN   = 2'b10
	} pfd_state_t;

endpackage
